/* all.f */
design/ctrlPkg.sv
design/aluDecode.sv
design/flowDecode.sv
design/ctrlMerge.sv
design/ctrlUnit.sv
bench/ctrlUnitTb.sv

/* run.sh */
#!/bin/sh
# Builds the control unit testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module ctrlUnitTb -f all.f -o simv

./obj_dir/simv | tee sim.log

if grep -q "TEST RESULT: FAIL" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
if ! grep -q "TEST RESULT: PASS" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation passed"

/* bench/ctrlUnitTb.sv */
/*
  Testbench for the control unit. A table of opcodes is applied back to back
  and every registered control word is checked against a model one cycle later.
*/
module ctrlUnitTb import ctrlPkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    typedef enum {
        clsRegReg, clsRegImm, clsUnary, clsIncDec, clsMove, clsCompare,
        clsLoad, clsStore, clsJump, clsHalt, clsNop, clsIllegal
    } testCls_t;

    typedef struct {
        logic [5:0] opc;
        testCls_t   cls;
        aluSel_t    alu;
        jumpCond_t  cond;
    } testEntry_t;

    // Expected control word
    typedef struct packed {
        regAddr_t    waddr;
        regAddr_t    raddr1;
        regAddr_t    raddr2;
        aluSel_t     aluOpSel;
        operandSel_t aluOp1;
        operandSel_t aluOp2;
        word_t       imm;
        memAddr_t    memAddr;
        jumpCond_t   jmpType;
        logic        valid;
        logic        sto;
        logic        ramWen;
        logic        ld;
        logic        jmp;
        logic        hlt;
        logic        mul;
        logic        illegal;
    } ctrlExp_t;

    logic        clk;
    logic        rst;
    instWord_t   inst;
    logic        instValid;
    regAddr_t    waddr;
    regAddr_t    raddr1;
    regAddr_t    raddr2;
    aluSel_t     aluOpSel;
    operandSel_t aluOp1;
    operandSel_t aluOp2;
    word_t       imm;
    memAddr_t    memAddr;
    logic        sto;
    logic        ramWen;
    logic        ld;
    logic        jmp;
    logic        hlt;
    logic        mul;
    logic        illegal;
    logic        ctrlValid;
    jumpCond_t   jmpType;

    testEntry_t tests[$];
    int         testErrs;
    int         passCount;
    int         failCount;
    int         cycles;
    int         cycleLimit;
    logic [31:0] hi;
    logic [31:0] lo;
    logic [34:0] body;
    ctrlExp_t   pendExp;
    string      pendLabel;
    logic       pending;

    ctrlUnit DUT (.*);

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycleLimit > 0 && cycles >= cycleLimit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycleLimit);
            $display("TEST RESULT: FAIL");
            $finish;
        end
    end

    task automatic addTest(input logic [5:0] opc, input testCls_t cls,
                           input aluSel_t alu, input jumpCond_t cond);
        testEntry_t t;
        t.opc  = opc;
        t.cls  = cls;
        t.alu  = alu;
        t.cond = cond;
        tests.push_back(t);
    endtask

    task automatic checkRegs(input string what, input regAddr_t got, input regAddr_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
            testErrs++;
        end
    endtask

    task automatic checkAlu(input aluSel_t gotSel, input aluSel_t expSel,
                            input operandSel_t gotOp1, input operandSel_t expOp1,
                            input operandSel_t gotOp2, input operandSel_t expOp2,
                            input word_t gotImm, input word_t expImm);
        if (gotSel !== expSel) begin
            $display("[FAIL] %0t ns: aluOpSel is %0d, expected %0d", $time, gotSel, expSel);
            testErrs++;
        end
        if (gotOp1 !== expOp1 || gotOp2 !== expOp2) begin
            $display("[FAIL] %0t ns: operands are %0d/%0d, expected %0d/%0d",
                     $time, gotOp1, gotOp2, expOp1, expOp2);
            testErrs++;
        end
        if (gotImm !== expImm) begin
            $display("[FAIL] %0t ns: imm is %h, expected %h", $time, gotImm, expImm);
            testErrs++;
        end
    endtask

    // Flags in the order valid, sto, ramWen, ld, jmp, hlt, mul, illegal
    task automatic checkFlow(input jumpCond_t gotCond, input jumpCond_t expCond,
                             input memAddr_t gotAddr, input memAddr_t expAddr,
                             input logic [7:0] gotFlags, input logic [7:0] expFlags);
        if (gotCond !== expCond) begin
            $display("[FAIL] %0t ns: jmpType is %0d, expected %0d", $time, gotCond, expCond);
            testErrs++;
        end
        if (gotAddr !== expAddr) begin
            $display("[FAIL] %0t ns: memAddr is %h, expected %h", $time, gotAddr, expAddr);
            testErrs++;
        end
        if (gotFlags !== expFlags) begin
            $display("[FAIL] %0t ns: flags are %b, expected %b", $time, gotFlags, expFlags);
            testErrs++;
        end
    endtask

    // Expected word built from the decode rules for each class
    function automatic ctrlExp_t expectOf(input testEntry_t t, input logic [34:0] b);
        ctrlExp_t e;
        regAddr_t op1;
        regAddr_t op2;
        e   = '0;
        op1 = b[34:32];
        op2 = b[31:29];
        if (t.cls == clsIllegal) begin
            e.valid   = 1'b1;
            e.illegal = 1'b1;
            return e;
        end
        e.valid   = 1'b1;
        e.jmpType = condAlways;
        case (t.cls)
            clsRegReg: begin
                e.waddr    = (t.opc == opMul) ? regAddr_t'(0) : op1;
                e.raddr1   = op1;
                e.raddr2   = op2;
                e.aluOpSel = t.alu;
                e.sto      = 1'b1;
                e.mul      = (t.opc == opMul);
            end
            clsRegImm, clsUnary, clsIncDec: begin
                e.waddr    = op1;
                e.raddr1   = op1;
                e.aluOpSel = t.alu;
                e.sto      = 1'b1;
                if (t.cls == clsRegImm) begin
                    e.aluOp2 = srcImm;
                    e.imm    = b[31:0];
                end
                if (t.cls == clsIncDec) begin
                    e.aluOp2 = srcOne;
                end
            end
            clsMove: begin
                e.waddr    = op1;
                e.aluOpSel = t.alu;
                e.sto      = 1'b1;
                if (t.opc == opMovi) begin
                    e.aluOp2 = srcImm;
                    e.imm    = b[31:0];
                end else begin
                    e.raddr1 = op2;
                end
            end
            clsCompare: begin
                e.raddr1   = op1;
                e.raddr2   = op2;
                e.aluOpSel = t.alu;
            end
            clsLoad: begin
                e.waddr   = op1;
                e.memAddr = b[31:21];
                e.ld      = 1'b1;
                e.sto     = 1'b1;
            end
            clsStore: begin
                e.raddr1  = op1;
                e.memAddr = b[31:21];
                e.ramWen  = 1'b1;
            end
            clsJump: begin
                e.jmp      = 1'b1;
                e.jmpType  = t.cond;
                e.aluOpSel = aluPassB;
                e.aluOp2   = srcImm;
                e.imm      = {22'b0, b[34:25]};
            end
            clsHalt: e.hlt = 1'b1;
            default: begin
            end
        endcase
        return e;
    endfunction

    task automatic finishTest(input string label, input ctrlExp_t e);
        testErrs = 0;
        checkRegs("waddr", waddr, e.waddr);
        checkRegs("raddr1", raddr1, e.raddr1);
        checkRegs("raddr2", raddr2, e.raddr2);
        checkAlu(aluOpSel, e.aluOpSel, aluOp1, e.aluOp1, aluOp2, e.aluOp2, imm, e.imm);
        checkFlow(jmpType, e.jmpType, memAddr, e.memAddr,
                  {ctrlValid, sto, ramWen, ld, jmp, hlt, mul, illegal},
                  {e.valid, e.sto, e.ramWen, e.ld, e.jmp, e.hlt, e.mul, e.illegal});
        if (testErrs == 0) begin
            passCount++;
            $display("[PASS] %0t ns: %s", $time, label);
        end else begin
            failCount++;
            $display("[FAIL] %0t ns: %s has %0d wrong field(s)", $time, label, testErrs);
        end
    endtask

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        // An undecodable word stays offered while reset is held
        inst       = {6'b000100, 35'b0};
        instValid  = 1'b1;
        passCount  = 0;
        failCount  = 0;
        cycles     = 0;
        pending    = 1'b0;
        void'($urandom(32'h6c51514b));

        addTest(opAnd, clsRegReg, aluAnd, condAlways);
        addTest(opOr, clsRegReg, aluOr, condAlways);
        addTest(opXor, clsRegReg, aluXor, condAlways);
        addTest(opXnor, clsRegReg, aluXnor, condAlways);
        addTest(opNor, clsRegReg, aluNor, condAlways);
        addTest(opNand, clsRegReg, aluNand, condAlways);
        addTest(opAdd, clsRegReg, aluAdd, condAlways);
        addTest(opSub, clsRegReg, aluSub, condAlways);
        addTest(opMul, clsRegReg, aluMul, condAlways);
        addTest(opDiv, clsRegReg, aluDiv, condAlways);
        addTest(opAndi, clsRegImm, aluAnd, condAlways);
        addTest(opOri, clsRegImm, aluOr, condAlways);
        addTest(opXori, clsRegImm, aluXor, condAlways);
        addTest(opXnori, clsRegImm, aluXnor, condAlways);
        addTest(opNori, clsRegImm, aluNor, condAlways);
        addTest(opNandi, clsRegImm, aluNand, condAlways);
        addTest(opAddi, clsRegImm, aluAdd, condAlways);
        addTest(opSubi, clsRegImm, aluSub, condAlways);
        addTest(opMuli, clsRegImm, aluMul, condAlways);
        addTest(opDivi, clsRegImm, aluDiv, condAlways);
        addTest(opNot, clsUnary, aluNot, condAlways);
        addTest(opSll, clsUnary, aluSll, condAlways);
        addTest(opSrl, clsUnary, aluSrl, condAlways);
        addTest(opInc, clsIncDec, aluAdd, condAlways);
        addTest(opDec, clsIncDec, aluSub, condAlways);
        addTest(opMov, clsMove, aluPass, condAlways);
        addTest(opMovi, clsMove, aluPassB, condAlways);
        addTest(opCmp, clsCompare, aluSub, condAlways);
        addTest(opLd, clsLoad, aluNot, condAlways);
        addTest(opSt, clsStore, aluNot, condAlways);
        addTest(opJmp, clsJump, aluPassB, condAlways);
        addTest(opJz, clsJump, aluPassB, condZero);
        addTest(opJnz, clsJump, aluPassB, condNotZero);
        addTest(opJeq, clsJump, aluPassB, condEqual);
        addTest(opJneq, clsJump, aluPassB, condNotEqual);
        addTest(opJg, clsJump, aluPassB, condGreater);
        addTest(opJl, clsJump, aluPassB, condLess);
        addTest(opJge, clsJump, aluPassB, condGreatEq);
        addTest(opJle, clsJump, aluPassB, condLessEq);
        addTest(opHlt, clsHalt, aluNot, condAlways);
        addTest(opNop, clsNop, aluNot, condAlways);
        addTest(6'b000100, clsIllegal, aluNot, condAlways);
        addTest(6'b000101, clsIllegal, aluNot, condAlways);
        addTest(6'b000110, clsIllegal, aluNot, condAlways);
        addTest(6'b000111, clsIllegal, aluNot, condAlways);
        cycleLimit = tests.size() * 2 + 20;

        repeat (8) @(posedge clk);
        #2;
        rst       = 1'b0;
        inst      = '0;
        instValid = 1'b0;
        finishTest("reset, idle outputs", ctrlExp_t'(0));

        // One instruction per cycle, each checked on the next
        foreach (tests[i]) begin
            @(posedge clk);
            #2;
            if (pending) begin
                finishTest(pendLabel, pendExp);
            end
            hi        = $urandom;
            lo        = $urandom;
            body      = {hi[2:0], lo};
            inst      = {tests[i].opc, body};
            instValid = 1'b1;
            pendExp   = expectOf(tests[i], body);
            pendLabel = $sformatf("test %0d opcode %b", i, tests[i].opc);
            pending   = 1'b1;
        end
        @(posedge clk);
        #2;
        finishTest(pendLabel, pendExp);

        // A decodable word without instValid must leave the outputs at zero
        inst      = {opMul, {hi[2:0], lo}};
        instValid = 1'b0;
        @(posedge clk);
        #2;
        finishTest("invalid cycle", ctrlExp_t'(0));

        $display("Tests run %0d, passed %0d, failed %0d",
                 passCount + failCount, passCount, failCount);
        if (failCount == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* design/ctrlUnit.sv */
/*
  Control unit top. Both decoders look at the same instruction word,
  the merger registers their combined result.
*/
module ctrlUnit import ctrlPkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  instWord_t   inst,
    input  logic        instValid,
    output regAddr_t    waddr,
    output regAddr_t    raddr1,
    output regAddr_t    raddr2,
    output aluSel_t     aluOpSel,
    output operandSel_t aluOp1,
    output operandSel_t aluOp2,
    output word_t       imm,
    output memAddr_t    memAddr,
    output logic        sto,
    output logic        ramWen,
    output logic        ld,
    output logic        jmp,
    output logic        hlt,
    output logic        mul,
    output logic        illegal,
    output logic        ctrlValid,
    output jumpCond_t   jmpType
);

    // ALU side
    logic        aluHit;
    regAddr_t    waddrA;
    regAddr_t    raddr1A;
    regAddr_t    raddr2A;
    aluSel_t     aluOpSelA;
    operandSel_t aluOp1A;
    operandSel_t aluOp2A;
    word_t       immA;
    logic        stoA;
    logic        mulA;

    // Flow side
    logic                       flowHit;
    regAddr_t                   waddrF;
    regAddr_t                   raddr1F;
    memAddr_t                   memAddrF;
    logic                       ramWenF;
    logic                       ldF;
    logic                       stoF;
    logic                       jmpF;
    jumpCond_t                  jmpTypeF;
    logic [JumpTargetWidth-1:0] targetF;
    logic                       hltF;

    aluDecode uAluDecode (
        .inst(inst), .aluHit(aluHit), .waddrA(waddrA), .raddr1A(raddr1A),
        .raddr2A(raddr2A), .aluOpSelA(aluOpSelA), .aluOp1A(aluOp1A),
        .aluOp2A(aluOp2A), .immA(immA), .stoA(stoA), .mul(mulA)
    );

    flowDecode uFlowDecode (
        .inst(inst), .flowHit(flowHit), .waddrF(waddrF), .raddr1F(raddr1F),
        .memAddrF(memAddrF), .ramWenF(ramWenF), .ldF(ldF), .stoF(stoF),
        .jmpF(jmpF), .jmpTypeF(jmpTypeF), .targetF(targetF), .hltF(hltF)
    );

    ctrlMerge uCtrlMerge (
        .clk(clk), .rst(rst), .instValid(instValid),
        .aluHit(aluHit), .waddrA(waddrA), .raddr1A(raddr1A), .raddr2A(raddr2A),
        .aluOpSelA(aluOpSelA), .aluOp1A(aluOp1A), .aluOp2A(aluOp2A),
        .immA(immA), .stoA(stoA), .mulA(mulA),
        .flowHit(flowHit), .waddrF(waddrF), .raddr1F(raddr1F),
        .memAddrF(memAddrF), .ramWenF(ramWenF), .ldF(ldF), .stoF(stoF),
        .jmpF(jmpF), .jmpTypeF(jmpTypeF), .targetF(targetF), .hltF(hltF),
        .waddr(waddr), .raddr1(raddr1), .raddr2(raddr2), .aluOpSel(aluOpSel),
        .aluOp1(aluOp1), .aluOp2(aluOp2), .imm(imm), .memAddr(memAddr),
        .sto(sto), .ramWen(ramWen), .ld(ld), .jmp(jmp), .hlt(hlt), .mul(mul),
        .illegal(illegal), .ctrlValid(ctrlValid), .jmpType(jmpType)
    );

endmodule

/* design/ctrlMerge.sv */
/*
  Joins the ALU and flow decodes, flags unknown opcodes and registers
  the control word. Outputs trail the accepted instruction by one cycle.
*/
module ctrlMerge import ctrlPkg::*; (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       instValid,
    input  logic                       aluHit,
    input  regAddr_t                   waddrA,
    input  regAddr_t                   raddr1A,
    input  regAddr_t                   raddr2A,
    input  aluSel_t                    aluOpSelA,
    input  operandSel_t                aluOp1A,
    input  operandSel_t                aluOp2A,
    input  word_t                      immA,
    input  logic                       stoA,
    input  logic                       mulA,
    input  logic                       flowHit,
    input  regAddr_t                   waddrF,
    input  regAddr_t                   raddr1F,
    input  memAddr_t                   memAddrF,
    input  logic                       ramWenF,
    input  logic                       ldF,
    input  logic                       stoF,
    input  logic                       jmpF,
    input  jumpCond_t                  jmpTypeF,
    input  logic [JumpTargetWidth-1:0] targetF,
    input  logic                       hltF,
    output regAddr_t                   waddr,
    output regAddr_t                   raddr1,
    output regAddr_t                   raddr2,
    output aluSel_t                    aluOpSel,
    output operandSel_t                aluOp1,
    output operandSel_t                aluOp2,
    output word_t                      imm,
    output memAddr_t                   memAddr,
    output logic                       sto,
    output logic                       ramWen,
    output logic                       ld,
    output logic                       jmp,
    output logic                       hlt,
    output logic                       mul,
    output logic                       illegal,
    output logic                       ctrlValid,
    output jumpCond_t                  jmpType
);

    logic anyHit;
    logic take;

    assign anyHit = aluHit | flowHit;
    assign take   = instValid & anyHit;

    always_ff @(posedge clk) begin
        if (rst) begin
            ctrlValid <= 1'b0;
            sto       <= 1'b0;
            ramWen    <= 1'b0;
            ld        <= 1'b0;
            jmp       <= 1'b0;
            hlt       <= 1'b0;
            mul       <= 1'b0;
            illegal   <= 1'b0;
        end else begin
            ctrlValid <= instValid;
            sto       <= take & (stoA | stoF);
            ramWen    <= take & ramWenF;
            ld        <= take & ldF;
            jmp       <= take & jmpF;
            hlt       <= take & hltF;
            mul       <= take & mulA;
            illegal   <= instValid & ~anyHit;
        end
    end

    // Payload, zero unless a decoded instruction is accepted
    always_ff @(posedge clk) begin
        if (!take) begin
            waddr    <= '0;
            raddr1   <= '0;
            raddr2   <= '0;
            aluOpSel <= aluSel_t'(0);
            aluOp1   <= operandSel_t'(0);
            aluOp2   <= operandSel_t'(0);
            imm      <= '0;
            memAddr  <= '0;
            jmpType  <= jumpCond_t'(0);
        end else begin
            waddr    <= waddrA | waddrF;
            raddr1   <= raddr1A | raddr1F;
            raddr2   <= raddr2A;
            aluOpSel <= jmpF ? aluPassB : aluOpSelA;
            aluOp1   <= aluOp1A;
            aluOp2   <= jmpF ? srcImm : aluOp2A;
            imm      <= jmpF ? {{(32 - JumpTargetWidth){1'b0}}, targetF} : immA;
            memAddr  <= memAddrF;
            jmpType  <= jmpTypeF;
        end
    end

    // A store to RAM never also writes the register file
    assert property (@(posedge clk) disable iff (rst) !(ramWen && sto));

    assert property (@(posedge clk) disable iff (rst) !(jmp && sto));

    // The two decoders own disjoint opcode sets
    assert property (@(posedge clk) disable iff (rst) !(aluHit && flowHit));

endmodule

/* design/flowDecode.sv */
/*
  Combinational decode of load, store, jumps, halt and no-op.
  Memory and jump fields come from their own views of the word.
*/
module flowDecode import ctrlPkg::*; (
    input  instWord_t                  inst,
    output logic                       flowHit,
    output regAddr_t                   waddrF,
    output regAddr_t                   raddr1F,
    output memAddr_t                   memAddrF,
    output logic                       ramWenF,
    output logic                       ldF,
    output logic                       stoF,
    output logic                       jmpF,
    output jumpCond_t                  jmpTypeF,
    output logic [JumpTargetWidth-1:0] targetF,
    output logic                       hltF
);

    opcode_t opc;

    function automatic jumpCond_t condOf(input opcode_t code);
        case (code)
            opJz:    condOf = condZero;
            opJnz:   condOf = condNotZero;
            opJeq:   condOf = condEqual;
            opJneq:  condOf = condNotEqual;
            opJg:    condOf = condGreater;
            opJl:    condOf = condLess;
            opJge:   condOf = condGreatEq;
            opJle:   condOf = condLessEq;
            default: condOf = condAlways;
        endcase
    endfunction

    assign opc = inst.memView.opcode;

    always_comb begin
        flowHit  = 1'b0;
        waddrF   = '0;
        raddr1F  = '0;
        memAddrF = '0;
        ramWenF  = 1'b0;
        ldF      = 1'b0;
        stoF     = 1'b0;
        jmpF     = 1'b0;
        jmpTypeF = condAlways;
        targetF  = '0;
        hltF     = 1'b0;
        case (opc)
            opLd: begin
                flowHit  = 1'b1;
                waddrF   = inst.memView.op1;
                memAddrF = inst.memView.addr;
                ldF      = 1'b1;
                stoF     = 1'b1;
            end
            opSt: begin
                flowHit  = 1'b1;
                raddr1F  = inst.memView.op1;
                memAddrF = inst.memView.addr;
                ramWenF  = 1'b1;
            end
            opJmp, opJz, opJnz, opJeq, opJneq, opJg, opJl, opJge, opJle: begin
                flowHit  = 1'b1;
                jmpF     = 1'b1;
                jmpTypeF = condOf(opc);
                targetF  = inst.jmpView.target;
            end
            opHlt: begin
                flowHit = 1'b1;
                hltF    = 1'b1;
            end
            opNop: flowHit = 1'b1;
            default: begin
            end
        endcase
    end

endmodule

/* design/aluDecode.sv */
/*
  Combinational decode of the arithmetic, logic, shift and move
  instructions. Drives zeros with aluHit low for any other opcode.
*/
module aluDecode import ctrlPkg::*; (
    input  instWord_t   inst,
    output logic        aluHit,
    output regAddr_t    waddrA,
    output regAddr_t    raddr1A,
    output regAddr_t    raddr2A,
    output aluSel_t     aluOpSelA,
    output operandSel_t aluOp1A,
    output operandSel_t aluOp2A,
    output word_t       immA,
    output logic        stoA,
    output logic        mul
);

    opcode_t  opc;
    regAddr_t op1;
    regAddr_t op2;

    // Binary operation shared by register and immediate forms
    function automatic aluSel_t binOp(input opcode_t code);
        case (code)
            opAnd, opAndi:   binOp = aluAnd;
            opOr, opOri:     binOp = aluOr;
            opXor, opXori:   binOp = aluXor;
            opXnor, opXnori: binOp = aluXnor;
            opNor, opNori:   binOp = aluNor;
            opNand, opNandi: binOp = aluNand;
            opAdd, opAddi:   binOp = aluAdd;
            opSub, opSubi:   binOp = aluSub;
            opMul, opMuli:   binOp = aluMul;
            opDiv, opDivi:   binOp = aluDiv;
            default:         binOp = aluPass;
        endcase
    endfunction

    assign opc = inst.regView.opcode;
    assign op1 = inst.regView.op1;
    assign op2 = inst.regView.op2;

    always_comb begin
        aluHit    = 1'b0;
        waddrA    = '0;
        raddr1A   = '0;
        raddr2A   = '0;
        aluOpSelA = aluSel_t'(0);
        aluOp1A   = srcBus;
        aluOp2A   = srcBus;
        immA      = '0;
        stoA      = 1'b0;
        mul       = 1'b0;
        case (opc)
            opAnd, opOr, opXor, opXnor, opNor, opNand, opAdd, opSub, opDiv: begin
                aluHit    = 1'b1;
                waddrA    = op1;
                raddr1A   = op1;
                raddr2A   = op2;
                aluOpSelA = binOp(opc);
                stoA      = 1'b1;
            end
            // Product lands in AX
            opMul: begin
                aluHit    = 1'b1;
                raddr1A   = op1;
                raddr2A   = op2;
                aluOpSelA = aluMul;
                stoA      = 1'b1;
                mul       = 1'b1;
            end
            opAndi, opOri, opXori, opXnori, opNori, opNandi, opAddi, opSubi,
            opMuli, opDivi: begin
                aluHit    = 1'b1;
                waddrA    = op1;
                raddr1A   = op1;
                aluOpSelA = binOp(opc);
                aluOp2A   = srcImm;
                immA      = inst[31:0];
                stoA      = 1'b1;
            end
            opNot, opSll, opSrl: begin
                aluHit    = 1'b1;
                waddrA    = op1;
                raddr1A   = op1;
                aluOpSelA = (opc == opNot) ? aluNot : ((opc == opSll) ? aluSll : aluSrl);
                stoA      = 1'b1;
            end
            opInc, opDec: begin
                aluHit    = 1'b1;
                waddrA    = op1;
                raddr1A   = op1;
                aluOpSelA = (opc == opInc) ? aluAdd : aluSub;
                aluOp2A   = srcOne;
                stoA      = 1'b1;
            end
            opMov: begin
                aluHit    = 1'b1;
                waddrA    = op1;
                raddr1A   = op2;
                aluOpSelA = aluPass;
                stoA      = 1'b1;
            end
            opMovi: begin
                aluHit    = 1'b1;
                waddrA    = op1;
                aluOpSelA = aluPassB;
                aluOp2A   = srcImm;
                immA      = inst[31:0];
                stoA      = 1'b1;
            end
            // Flags only
            opCmp: begin
                aluHit    = 1'b1;
                raddr1A   = op1;
                raddr2A   = op2;
                aluOpSelA = aluSub;
            end
            default: begin
            end
        endcase
    end

    always_comb begin
        assert (!mul || waddrA == '0)
            else $error("mul raised with destination %0d", waddrA);
    end

endmodule

/* design/ctrlPkg.sv */
/*
  Shared types for the control unit: opcodes, ALU and operand codes,
  jump conditions and the 41-bit instruction word with its three views.
*/
package ctrlPkg;

    localparam int JumpTargetWidth = 10;

    typedef logic [2:0]  regAddr_t;
    typedef logic [10:0] memAddr_t;
    typedef logic [31:0] word_t;

    typedef enum logic [5:0] {
        opNop   = 6'b000000,
        opNot   = 6'b000001,
        opInc   = 6'b000010,
        opDec   = 6'b000011,
        opMov   = 6'b001000,
        opCmp   = 6'b001010,
        opAnd   = 6'b001011,
        opOr    = 6'b001100,
        opXor   = 6'b001101,
        opXnor  = 6'b001110,
        opNor   = 6'b001111,
        opNand  = 6'b010000,
        opAdd   = 6'b010001,
        opSub   = 6'b010010,
        opMul   = 6'b010011,
        opDiv   = 6'b010100,
        opMovi  = 6'b010101,
        opAndi  = 6'b010111,
        opOri   = 6'b011000,
        opXori  = 6'b011001,
        opXnori = 6'b011010,
        opNori  = 6'b011011,
        opNandi = 6'b011100,
        opSll   = 6'b011101,
        opSrl   = 6'b011110,
        opAddi  = 6'b011111,
        opSubi  = 6'b100000,
        opMuli  = 6'b100001,
        opDivi  = 6'b100010,
        opJmp   = 6'b100101,
        opJz    = 6'b100110,
        opJnz   = 6'b100111,
        opJeq   = 6'b101000,
        opJneq  = 6'b101001,
        opJg    = 6'b101010,
        opJl    = 6'b101011,
        opJge   = 6'b101100,
        opJle   = 6'b101101,
        opLd    = 6'b110000,
        opSt    = 6'b110001,
        opHlt   = 6'b111111
    } opcode_t;

    typedef enum logic [3:0] {
        aluNot   = 4'd0,
        aluAnd   = 4'd1,
        aluOr    = 4'd2,
        aluXor   = 4'd3,
        aluXnor  = 4'd4,
        aluNor   = 4'd5,
        aluNand  = 4'd6,
        aluSll   = 4'd7,
        aluSrl   = 4'd8,
        aluAdd   = 4'd9,
        aluSub   = 4'd10,
        aluMul   = 4'd11,
        aluDiv   = 4'd12,
        aluPass  = 4'd13,
        aluPassB = 4'd14
    } aluSel_t;

    // Where each ALU operand comes from
    typedef enum logic [1:0] {
        srcBus = 2'd0,
        srcRam = 2'd1,
        srcImm = 2'd2,
        srcOne = 2'd3
    } operandSel_t;

    // Codes 8 and 9 stay reserved (carry conditions)
    typedef enum logic [3:0] {
        condZero     = 4'd0,
        condNotZero  = 4'd1,
        condEqual    = 4'd2,
        condNotEqual = 4'd3,
        condGreater  = 4'd4,
        condLess     = 4'd5,
        condGreatEq  = 4'd6,
        condLessEq   = 4'd7,
        condAlways   = 4'd10
    } jumpCond_t;

    // Register view, low 32 bits double as the immediate
    typedef struct packed {
        opcode_t     opcode;
        regAddr_t    op1;
        regAddr_t    op2;
        logic [28:0] rest;
    } regFmt_t;

    typedef struct packed {
        opcode_t     opcode;
        regAddr_t    op1;
        memAddr_t    addr;
        logic [20:0] pad;
    } memFmt_t;

    typedef struct packed {
        opcode_t                    opcode;
        logic [JumpTargetWidth-1:0] target;
        logic [24:0]                pad;
    } jmpFmt_t;

    typedef union packed {
        regFmt_t regView;
        memFmt_t memView;
        jmpFmt_t jmpView;
    } instWord_t;

endpackage
